// ==== common/zw_defines.svh ====
`ifndef ZW_DEFINES_SVH
`define ZW_DEFINES_SVH

// global widths for the core-to-wishbone bridge
// core side is byte addressed, bus side is word addressed

// core byte address, 1 MB space
`define ZW_ADDR_W 20

// data word on both sides
`define ZW_DATA_W 16

// byte lanes per word, also the sel width
`define ZW_LANES  2

// word address on the bus is ZW_ADDR_W-1 bits wide (bit 0 dropped)

`endif

// ==== common/cpu_req_pkg.sv ====
package cpu_req_pkg;

  // size of a core access
  // byte lane follows addr[0], word may be unaligned
  typedef enum logic {
    ACC_BYTE = 1'b0,  // single byte, sign-extended on read
    ACC_WORD = 1'b1   // 16-bit word
  } acc_size_t;

  // address space of the access
  // goes straight out as the wishbone tag
  typedef enum logic {
    SPC_MEM = 1'b0,   // memory space
    SPC_IO  = 1'b1    // i/o space, wb_tga_o high
  } acc_space_t;

  // one request in flight at a time, four-phase req/ack
  // core holds addr/data/size/space from req up to ack

endpackage

// ==== common/wb_bus_pkg.sv ====
`include "zw_defines.svh"

package wb_bus_pkg;

  // one select bit per byte lane
  // bit 0 low lane [7:0], bit 1 high lane [15:8]
  typedef logic [`ZW_LANES-1:0] wb_sel_t;

  // word address, core byte address without bit 0
  typedef logic [`ZW_ADDR_W-2:0] wb_wadr_t;

  // cycle engine states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // waiting for start
    PHASE1 = 2'd1,  // first bus cycle
    PHASE2 = 2'd2,  // second cycle of a split word
    DONE   = 2'd3   // one settle cycle back to idle
  } eng_state_t;

  // PHASE2 begins with stb low for one cycle
  // stb rises again once the second address is loaded

endpackage

// ==== logic/access_decode.sv ====
`timescale 1ns/1ps
`include "zw_defines.svh"

module access_decode
  import cpu_req_pkg::*, wb_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic [`ZW_ADDR_W-1:0] addr_i,
  input  logic [`ZW_DATA_W-1:0] wdata_i,
  input  logic                  we_i,
  input  acc_size_t             size_i,
  input  acc_space_t            space_i,
  input  logic                  done_i,     // merge side, cycle not yet closed
  output logic                  start_o,
  output logic                  split_o,
  output wb_wadr_t              adr1_o,
  output wb_wadr_t              adr2_o,
  output wb_sel_t               sel1_o,
  output wb_sel_t               sel2_o,
  output logic [`ZW_DATA_W-1:0] wdat1_o,
  output logic [`ZW_DATA_W-1:0] wdat2_o,
  output logic                  we_o,
  output acc_space_t            space_o,
  output logic                  odd_o,
  output acc_size_t             size_o
);

  logic                  busy_q;   // request taken, waiting on done
  logic                  cap_q;    // capture seen last edge
  logic                  capture;
  logic                  odd;
  logic                  is_byte;
  wb_sel_t               sel1_d;
  logic [`ZW_DATA_W-1:0] swapped;  // core bytes exchanged

  assign capture = req_i & ~busy_q & ~done_i;  // new request only once the last one closed
  assign odd     = addr_i[0];
  assign is_byte = (size_i == ACC_BYTE);
  assign swapped = {wdata_i[7:0], wdata_i[15:8]};

  // odd byte or first half of odd word -> high lane
  assign sel1_d = odd ? 2'b10 : (is_byte ? 2'b01 : 2'b11);

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      cap_q   <= 1'b0;
      start_o <= 1'b0;
    end else begin
      cap_q   <= capture;
      start_o <= cap_q;        // fields settled, kick the engine
      if (capture)
        busy_q <= 1'b1;
      else if (done_i)
        busy_q <= 1'b0;        // done itself blocks until ack drops
    end
  end

  // request fields, held until the next capture
  always_ff @(posedge wb_clk_i) begin
    if (capture) begin
      split_o <= ~is_byte & odd;                      // unaligned word, two cycles
      adr1_o  <= addr_i[`ZW_ADDR_W-1:1];
      adr2_o  <= addr_i[`ZW_ADDR_W-1:1] + 1'b1;       // next word
      sel1_o  <= sel1_d;
      sel2_o  <= 2'b01;                               // second half always low lane
      wdat1_o <= odd ? swapped : wdata_i;             // core low byte onto high lane
      wdat2_o <= swapped;                             // core high byte onto low lane
      we_o    <= we_i;
      space_o <= space_i;
      odd_o   <= odd;
      size_o  <= size_i;
    end
  end

  // merge must have released the previous cycle before a new start
  a_start_closed: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    start_o |-> !done_i)
    else $error("start pulsed while the previous four-phase cycle was still open");

endmodule

// ==== wb_master/wb_cycle_engine.sv ====
`timescale 1ns/1ps
`include "zw_defines.svh"

module wb_cycle_engine
  import wb_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  logic                  split_i,   // held by decode for the whole request
  input  wb_wadr_t              adr1_i,
  input  wb_wadr_t              adr2_i,
  input  wb_sel_t               sel1_i,
  input  wb_sel_t               sel2_i,
  input  logic [`ZW_DATA_W-1:0] wdat1_i,
  input  logic [`ZW_DATA_W-1:0] wdat2_i,
  input  logic                  we_i,
  input  logic                  space_i,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output wb_wadr_t              wb_adr_o,
  output wb_sel_t               wb_sel_o,
  output logic [`ZW_DATA_W-1:0] wb_dat_o,
  output logic                  wb_tga_o,
  input  logic                  wb_ack_i,
  output logic                  phase_done_o,
  output logic                  phase2_o,
  output logic                  last_o
);

  eng_state_t state_q;
  logic       load1;   // first phase set up
  logic       load2;   // second phase set up

  assign load1 = (state_q == IDLE) & start_i;
  assign load2 = (state_q == PHASE1) & wb_ack_i & split_i;

  // handshake towards merge, valid in the ack cycle
  assign phase_done_o = wb_stb_o & wb_ack_i;
  assign phase2_o     = (state_q == PHASE2);
  assign last_o       = phase_done_o & (phase2_o | ~split_i);  // no second phase pending

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      wb_stb_o <= 1'b0;
      wb_cyc_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            wb_stb_o <= 1'b1;
            wb_cyc_o <= 1'b1;
            state_q  <= PHASE1;
          end
        end
        PHASE1: begin
          if (wb_ack_i) begin         // slave may stretch this
            wb_stb_o <= 1'b0;
            wb_cyc_o <= 1'b0;
            state_q  <= split_i ? PHASE2 : DONE;
          end
        end
        PHASE2: begin
          if (!wb_stb_o) begin        // gap cycle after phase 1
            wb_stb_o <= 1'b1;
            wb_cyc_o <= 1'b1;
          end else if (wb_ack_i) begin
            wb_stb_o <= 1'b0;
            wb_cyc_o <= 1'b0;
            state_q  <= DONE;
          end
        end
        DONE:    state_q <= IDLE;     // merge raises ack here
        default: state_q <= IDLE;
      endcase
    end
  end

  // bus payload, loaded while stb is low
  always_ff @(posedge wb_clk_i) begin
    if (load1) begin
      wb_adr_o <= adr1_i;
      wb_sel_o <= sel1_i;
      wb_dat_o <= wdat1_i;
      wb_we_o  <= we_i;
      wb_tga_o <= space_i;            // io vs mem
    end else if (load2) begin
      wb_adr_o <= adr2_i;             // next word, low lane
      wb_sel_o <= sel2_i;
      wb_dat_o <= wdat2_i;
    end
  end

  a_stb_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_cyc_o)
    else $error("wishbone stb high without cyc");

  a_sel_nz: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> (wb_sel_o != '0))
    else $error("wishbone strobe with no byte lane selected");

  // phase waiting on the slave keeps its request steady
  a_hold: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (wb_stb_o && !wb_ack_i) |=>
      ($stable(wb_adr_o) && $stable(wb_sel_o) && $stable(wb_dat_o)))
    else $error("wishbone address, select or data moved before ack");

endmodule

// ==== logic/read_merge.sv ====
`timescale 1ns/1ps
`include "zw_defines.svh"

module read_merge
  import cpu_req_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  phase_done_i,
  input  logic                  phase2_i,
  input  logic                  last_i,
  input  logic [`ZW_DATA_W-1:0] wb_dat_i,
  input  logic                  odd_i,
  input  acc_size_t             size_i,
  input  logic                  we_i,
  input  logic                  req_i,
  output logic [`ZW_DATA_W-1:0] rdata_o,
  output logic                  ack_o,
  output logic                  done_o
);

  logic [`ZW_DATA_W-1:0] lo_sext;  // low lane, sign-extended
  logic [`ZW_DATA_W-1:0] hi_sext;  // high lane, sign-extended
  logic                  is_byte;

  assign lo_sext = {{8{wb_dat_i[7]}}, wb_dat_i[7:0]};
  assign hi_sext = {{8{wb_dat_i[15]}}, wb_dat_i[15:8]};
  assign is_byte = (size_i == ACC_BYTE);

  // bus data sampled in the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (phase_done_i && !we_i) begin   // writes keep the old value
      if (phase2_i)
        rdata_o[15:8] <= wb_dat_i[7:0];    // upper byte from next word
      else if (is_byte)
        rdata_o <= odd_i ? hi_sext : lo_sext;
      else if (odd_i)
        rdata_o[7:0] <= wb_dat_i[15:8];    // split word, lower half
      else
        rdata_o <= wb_dat_i;               // aligned word
    end
  end

  // ack side of the four-phase port
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else if (last_i) begin
      ack_o <= 1'b1;                   // same edge rdata settles
    end else if (ack_o && !req_i) begin
      ack_o <= 1'b0;                   // core has taken the data
    end
  end

  // busy from the last bus ack until the core lets go
  assign done_o = last_i | ack_o;

  // core raises req first, ack only answers it
  a_ack_after_req: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack raised towards the core with no request pending");

endmodule

// ==== logic/cpu_wb_bridge.sv ====
`timescale 1ns/1ps
`include "zw_defines.svh"

module cpu_wb_bridge
  import cpu_req_pkg::*, wb_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  // core port
  input  logic                  req_i,
  input  logic [`ZW_ADDR_W-1:0] addr_i,
  input  logic [`ZW_DATA_W-1:0] wdata_i,
  input  logic                  we_i,
  input  acc_size_t             size_i,
  input  acc_space_t            space_i,
  output logic [`ZW_DATA_W-1:0] rdata_o,
  output logic                  ack_o,
  // wishbone master
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output wb_wadr_t              wb_adr_o,
  output wb_sel_t               wb_sel_o,
  output logic [`ZW_DATA_W-1:0] wb_dat_o,
  output logic                  wb_tga_o,
  input  logic [`ZW_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i
);

  logic                  start, split, we, odd, done;
  wb_wadr_t              adr1, adr2;
  wb_sel_t               sel1, sel2;
  logic [`ZW_DATA_W-1:0] wdat1, wdat2;
  acc_space_t            space;
  acc_size_t             size;
  logic                  phase_done, phase2, last;

  access_decode u_decode (
    .wb_clk_i (wb_clk_i), .rst_n_i (rst_n_i),
    .req_i    (req_i),    .addr_i  (addr_i),  .wdata_i (wdata_i),
    .we_i     (we_i),     .size_i  (size_i),  .space_i (space_i),
    .done_i   (done),
    .start_o  (start),    .split_o (split),
    .adr1_o   (adr1),     .adr2_o  (adr2),
    .sel1_o   (sel1),     .sel2_o  (sel2),
    .wdat1_o  (wdat1),    .wdat2_o (wdat2),
    .we_o     (we),       .space_o (space),   .odd_o   (odd),
    .size_o   (size)
  );

  wb_cycle_engine u_engine (
    .wb_clk_i (wb_clk_i), .rst_n_i  (rst_n_i),
    .start_i  (start),    .split_i  (split),
    .adr1_i   (adr1),     .adr2_i   (adr2),
    .sel1_i   (sel1),     .sel2_i   (sel2),
    .wdat1_i  (wdat1),    .wdat2_i  (wdat2),
    .we_i     (we),       .space_i  (space),   // enum into plain tag bit
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o), .wb_sel_o (wb_sel_o), .wb_dat_o (wb_dat_o),
    .wb_tga_o (wb_tga_o), .wb_ack_i (wb_ack_i),
    .phase_done_o (phase_done), .phase2_o (phase2), .last_o (last)
  );

  read_merge u_merge (
    .wb_clk_i     (wb_clk_i),   .rst_n_i  (rst_n_i),
    .phase_done_i (phase_done), .phase2_i (phase2), .last_i (last),
    .wb_dat_i     (wb_dat_i),   // bus read data straight in
    .odd_i        (odd),        .size_i   (size),   .we_i   (we),
    .req_i        (req_i),
    .rdata_o      (rdata_o),    .ack_o    (ack_o),  .done_o (done)
  );

endmodule

// ==== bench/wb_mem_model.sv ====
`timescale 1ns/1ps
`include "zw_defines.svh"

module wb_mem_model
  import wb_bus_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  wb_wadr_t              wb_adr_i,
  input  wb_sel_t               wb_sel_i,
  input  logic [`ZW_DATA_W-1:0] wb_dat_i,
  output logic [`ZW_DATA_W-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  output int                    wr_cnt_o   // write phases taken, the write log
);

  logic [`ZW_DATA_W-1:0] mem [0:1023];    // 1k words, wraps on adr[9:0]
  logic [9:0]            idx;
  logic [1:0]            wait_q;          // cycles left before the next ack
  int                    seed = 43;

  // byte at byte address b, whole address folded in
  function automatic logic [7:0] fill_byte(int b);
    return 8'(b) ^ 8'h5a ^ {b[10:8], 5'b0};
  endfunction

  assign idx = wb_adr_i[9:0];

  initial begin
    for (int w = 0; w < 1024; w++)
      mem[w] = {fill_byte(2 * w + 1), fill_byte(2 * w)};  // odd byte on high lane
  end

  always @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
      wait_q   <= 2'd0;
      wr_cnt_o <= 0;
    end else begin
      wb_ack_o <= 1'b0;                          // ack lasts one cycle
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;               // slave still busy
        end else begin
          wb_ack_o <= 1'b1;
          wb_dat_o <= mem[idx];
          wait_q   <= 2'($random(seed));         // 0..3 wait cycles for the next phase
          if (wb_we_i) begin
            if (wb_sel_i[0])
              mem[idx][7:0] <= wb_dat_i[7:0];
            if (wb_sel_i[1])
              mem[idx][15:8] <= wb_dat_i[15:8];
            wr_cnt_o <= wr_cnt_o + 1;
          end
        end
      end
    end
  end

endmodule

// ==== bench/tb_cpu_wb_bridge.sv ====
`timescale 1ns/1ps
`include "zw_defines.svh"

module tb_cpu_wb_bridge
  import cpu_req_pkg::*, wb_bus_pkg::*;
();

  localparam int N_REQ      = 40;
  localparam int N_DIRECTED = 12;
  localparam int MAX_CYCLES = N_REQ * 20;  // a request needs at most about 16 cycles

  logic                  wb_clk_i, rst_n_i, req_i, we_i, ack_o;
  logic [`ZW_ADDR_W-1:0] addr_i;
  logic [`ZW_DATA_W-1:0] wdata_i, rdata_o, wb_dat_o, wb_dat_i;
  acc_size_t             size_i;
  acc_space_t            space_i;
  logic                  wb_cyc_o, wb_stb_o, wb_we_o, wb_tga_o, wb_ack_i;
  wb_wadr_t              wb_adr_o;
  wb_sel_t               wb_sel_o;
  int                    wr_cnt;

  // expected bus plan of the request in flight
  int                    exp_phases;
  int                    exp_wr;
  wb_wadr_t              exp_adr [2];
  wb_sel_t               exp_sel [2];
  logic [`ZW_DATA_W-1:0] exp_dat [2];
  logic [`ZW_DATA_W-1:0] exp_rdata;
  logic [7:0]            shadow [0:2047];  // byte image of the memory
  wb_wadr_t              cur_adr;
  wb_sel_t               cur_sel;
  logic [`ZW_DATA_W-1:0] cur_dat;
  int                    phase_cnt;        // bus acks seen in this request
  int                    cycles = 0;
  int                    val_errs = 0;
  int                    proto_errs = 0;
  int                    seed = 43;

  cpu_wb_bridge u_cpu_wb_bridge (.*);

  wb_mem_model u_mem (
    .wb_clk_i (wb_clk_i), .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_o), .wb_stb_i (wb_stb_o), .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o), .wb_sel_i (wb_sel_o), .wb_dat_i (wb_dat_o),
    .wb_dat_o (wb_dat_i), .wb_ack_o (wb_ack_i), .wr_cnt_o (wr_cnt)
  );

  function automatic logic [7:0] fill_byte(int b);
    return 8'(b) ^ 8'h5a ^ {b[10:8], 5'b0};
  endfunction

  function automatic logic [15:0] lane_mask(wb_sel_t s);
    return {{8{s[1]}}, {8{s[0]}}};
  endfunction

  task automatic report_value(string name, logic [31:0] exp, logic [31:0] act);
    val_errs++;
    $display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
  endtask

  task automatic report_protocol(string msg);
    proto_errs++;
    $display("protocol error: %s", msg);
  endtask

  assign cur_adr = exp_adr[phase_cnt[0]];
  assign cur_sel = exp_sel[phase_cnt[0]];
  assign cur_dat = exp_dat[phase_cnt[0]];

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      phase_cnt <= 0;
    else if (ack_o)
      phase_cnt <= 0;                       // request closed
    else if (wb_stb_o && wb_ack_i)
      phase_cnt <= phase_cnt + 1;
  end

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout after %0d cycles, a request never completed", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  a_reset_quiet: assert property (@(posedge wb_clk_i)
    !rst_n_i |-> (!ack_o && !wb_stb_o && !wb_cyc_o))
    else report_protocol("ack, stb or cyc high during reset");
  a_ack_rise: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i)) else report_protocol("ack rose while req was low");
  a_ack_fall: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    $fell(ack_o) |-> !$past(req_i)) else report_protocol("ack fell while req was high");
  // capture edge, start edge, then stb registered high
  a_req_to_stb: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    ($rose(wb_stb_o) && phase_cnt == 0) |-> ($past(req_i, 3) && !$past(req_i, 4)))
    else report_protocol("first strobe not two cycles after req was sampled");
  a_last_to_ack: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (wb_stb_o && wb_ack_i && phase_cnt == exp_phases - 1) |=> $rose(ack_o))
    else report_protocol("ack did not follow the last bus ack by one cycle");
  a_phases: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> phase_cnt == exp_phases)
    else report_protocol("wrong number of bus cycles for one request");
  a_adr: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_adr_o == cur_adr)
    else report_value("wb_adr_o", 32'($sampled(cur_adr)), 32'($sampled(wb_adr_o)));
  a_sel: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_sel_o == cur_sel)
    else report_value("wb_sel_o", 32'($sampled(cur_sel)), 32'($sampled(wb_sel_o)));
  a_wdat: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (wb_stb_o && wb_we_o) |-> ((wb_dat_o ^ cur_dat) & lane_mask(wb_sel_o)) == '0)
    else report_value("wb_dat_o", 32'($sampled(cur_dat)), 32'($sampled(wb_dat_o)));
  a_we: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_we_o == we_i)
    else report_value("wb_we_o", 32'($sampled(we_i)), 32'($sampled(wb_we_o)));
  a_tga: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_tga_o == space_i)
    else report_value("wb_tga_o", 32'($sampled(space_i)), 32'($sampled(wb_tga_o)));
  a_stb_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_stb_o |-> wb_cyc_o) else report_protocol("stb high without cyc");
  a_hold: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_sel_o)))
    else report_protocol("address or select moved while the slave was waiting");
  a_rdata: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    ($rose(ack_o) && !we_i) |-> rdata_o == exp_rdata)
    else report_value("rdata_o", 32'($sampled(exp_rdata)), 32'($sampled(rdata_o)));

  // one four-phase request, lo byte at a and hi byte at a+1
  task automatic access(input logic [`ZW_ADDR_W-1:0] a, input acc_size_t sz,
                        input logic we, input acc_space_t sp, input logic [15:0] wd);
    int lo;
    int hi;
    lo = int'(a[10:0]);
    hi = lo + 1;
    @(negedge wb_clk_i);
    exp_adr[0] = a[`ZW_ADDR_W-1:1];
    exp_adr[1] = a[`ZW_ADDR_W-1:1] + 1'b1;
    exp_sel[1] = 2'b01;
    exp_dat[1] = {8'h00, wd[15:8]};          // upper core byte, low lane of next word
    if (sz == ACC_BYTE) begin
      exp_phases = 1;
      exp_sel[0] = a[0] ? 2'b10 : 2'b01;
      exp_dat[0] = {wd[7:0], wd[7:0]};       // only the selected lane counts
      exp_rdata  = {{8{shadow[lo][7]}}, shadow[lo]};
    end else begin
      exp_phases = a[0] ? 2 : 1;
      exp_sel[0] = a[0] ? 2'b10 : 2'b11;
      exp_dat[0] = a[0] ? {wd[7:0], 8'h00} : wd;
      exp_rdata  = {shadow[hi], shadow[lo]};
    end
    if (we)
      exp_wr += exp_phases;
    addr_i  = a;
    size_i  = sz;
    we_i    = we;
    space_i = sp;
    wdata_i = wd;
    req_i   = 1'b1;
    while (!ack_o)
      @(negedge wb_clk_i);
    if (we) begin
      shadow[lo] = wd[7:0];
      if (sz == ACC_WORD)
        shadow[hi] = wd[15:8];
    end
    req_i = 1'b0;
    while (ack_o)
      @(negedge wb_clk_i);
  endtask

  initial begin
    logic [`ZW_ADDR_W-1:0] ra;
    logic [31:0]           rbits;
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    we_i    = 1'b0;
    size_i  = ACC_BYTE;
    space_i = SPC_MEM;
    exp_wr  = 0;
    exp_phases = 1;
    for (int b = 0; b < 2048; b++)
      shadow[b] = fill_byte(b);
    repeat (2) @(negedge wb_clk_i);
    rst_n_i = 1'b1;

    access(20'h00010, ACC_WORD, 1'b0, SPC_MEM, 16'h0000);  // aligned word
    access(20'h00010, ACC_WORD, 1'b1, SPC_MEM, 16'hbeef);
    access(20'h00010, ACC_WORD, 1'b0, SPC_MEM, 16'h0000);
    access(20'h00020, ACC_BYTE, 1'b0, SPC_MEM, 16'h0000);  // even byte
    access(20'h00021, ACC_BYTE, 1'b0, SPC_MEM, 16'h0000);  // odd byte
    access(20'h00022, ACC_BYTE, 1'b1, SPC_IO,  16'h1185);  // bit 7 set
    access(20'h00022, ACC_BYTE, 1'b0, SPC_IO,  16'h0000);  // sign-extended
    access(20'h00023, ACC_BYTE, 1'b1, SPC_MEM, 16'h227f);
    access(20'h00023, ACC_BYTE, 1'b0, SPC_MEM, 16'h0000);
    access(20'h00033, ACC_WORD, 1'b0, SPC_MEM, 16'h0000);  // split read
    access(20'h00045, ACC_WORD, 1'b1, SPC_IO,  16'ha55a);  // split write
    access(20'h00045, ACC_WORD, 1'b0, SPC_IO,  16'h0000);
    for (int i = N_DIRECTED; i < N_REQ; i++) begin
      ra    = 20'($unsigned($random(seed)) % 2046);
      rbits = $random(seed);
      access(ra, acc_size_t'(rbits[0]), rbits[1], acc_space_t'(rbits[2]), rbits[31:16]);
    end
    repeat (2) @(negedge wb_clk_i);

    a_wr_log: assert (wr_cnt == exp_wr)
      else report_value("wr_cnt", 32'(exp_wr), 32'(wr_cnt));
    $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+common
common/cpu_req_pkg.sv
common/wb_bus_pkg.sv
logic/access_decode.sv
wb_master/wb_cycle_engine.sv
logic/read_merge.sv
logic/cpu_wb_bridge.sv
bench/wb_mem_model.sv
bench/tb_cpu_wb_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_cpu_wb_bridge -o tb_sim \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
